//--- cctv_pkg.sv
`default_nettype none

package cctv_pkg;

    // ********************
    // Frame geometry
    localparam int frame_width  = 16;                         // Pixels per line
    localparam int frame_height = 12;                         // Lines per frame
    localparam int frame_pixels = frame_width * frame_height; // Pixels per frame

    localparam int pix_addr_w   = $clog2(frame_pixels);       // Frame store address bits
    localparam int diff_count_w = $clog2(frame_pixels + 1);   // Count must reach frame_pixels
    localparam int line_cnt_w   = $clog2(frame_height + 1);   // Line count up to frame_height

    // ********************
    // Data types
    typedef logic [11:0]             rgb_t;        // RGB444 with red on top
    typedef logic [3:0]              gray_t;       // Gray level
    typedef logic [pix_addr_w-1:0]   pix_addr_t;   // Frame store address
    typedef logic [diff_count_w-1:0] diff_count_t; // Changed pixels per frame
    typedef logic [line_cnt_w-1:0]   line_cnt_t;   // Lines seen in current frame
    typedef logic [7:0]              cam_byte_t;   // OV7670 data bus
    typedef logic [3:0]              pix_thresh_t; // Per pixel difference limit
    typedef logic [7:0]              det_thresh_t; // Changed pixel count limit
    typedef logic [7:0]              gray_sum_t;   // Weighted channel sum, max 240

    // ********************
    // Gray weights
    // Weights add up to 16 so the sum fits one nibble after a shift by four
    localparam gray_sum_t gray_w_red   = 8'd5;
    localparam gray_sum_t gray_w_green = 8'd9;
    localparam gray_sum_t gray_w_blue  = 8'd2;

endpackage

`default_nettype wire

//--- pixel_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pixel_if;

    logic                pix_valid; // One cycle per captured pixel
    cctv_pkg::pix_addr_t pix_addr;  // Frame store address of the pixel
    cctv_pkg::rgb_t      pix_rgb;   // Packed RGB444 value
    logic                frame_end; // One cycle strobe at vref rise

    // Capture side drives everything
    modport src (
        output pix_valid,
        output pix_addr,
        output pix_rgb,
        output frame_end
    );

    // Differencing side only listens since there is no ready
    modport dst (
        input pix_valid,
        input pix_addr,
        input pix_rgb,
        input frame_end
    );

endinterface

`default_nettype wire

//--- camera_capture.sv
`timescale 1ns/1ps
`default_nettype none

module camera_capture (
    input  wire                   pclk,
    input  wire                   rst_n,
    input  wire                   href,
    input  wire                   vref,
    input  wire cctv_pkg::cam_byte_t ov7670_data,
    pixel_if.src                  pix
);

    logic                  byte_phase; // High when the first byte is held
    cctv_pkg::cam_byte_t   first_byte; // R5 and upper G bits
    logic                  vref_d;     // Previous vref level
    logic                  href_d;     // Previous href level
    cctv_pkg::pix_addr_t   wr_addr;    // Next frame store address
    logic                  addr_full;  // Frame store already filled
    cctv_pkg::line_cnt_t   line_cnt;   // Lines finished in this frame
    logic                  vref_rise;
    logic                  href_fall;
    logic                  accept;     // Pixel may go to the frame store
    cctv_pkg::rgb_t        packed_rgb;

    assign vref_rise = vref & ~vref_d;
    assign href_fall = href_d & ~href;

    // Nothing is stored past the frame size
    assign accept = ~addr_full &
                    (line_cnt != cctv_pkg::line_cnt_t'(cctv_pkg::frame_height));

    // Top four bits of R5 G6 B5
    assign packed_rgb = {first_byte[7:4],                 // Red
                         first_byte[2:0], ov7670_data[7], // Green
                         ov7670_data[4:1]};               // Blue

    // ********************
    // Byte pairing and address tracking
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            byte_phase    <= 1'b0;
            vref_d        <= 1'b0;
            href_d        <= 1'b0;
            wr_addr       <= '0;
            addr_full     <= 1'b0;
            line_cnt      <= '0;
            pix.pix_valid <= 1'b0;
            pix.frame_end <= 1'b0;
        end else begin
            vref_d        <= vref;
            href_d        <= href;
            pix.pix_valid <= 1'b0;
            pix.frame_end <= vref_rise;                      // Frame closes at vref rise
            if (vref) begin
                byte_phase <= 1'b0;                          // Restart addressing for next frame
                wr_addr    <= '0;
                addr_full  <= 1'b0;
                line_cnt   <= '0;
            end else if (href) begin
                byte_phase <= ~byte_phase;
                if (byte_phase && accept) begin
                    pix.pix_valid <= 1'b1;                   // Second byte completes the pixel
                    wr_addr       <= wr_addr + cctv_pkg::pix_addr_t'(1);
                    if (wr_addr == cctv_pkg::pix_addr_t'(cctv_pkg::frame_pixels - 1)) begin
                        addr_full <= 1'b1;                   // Last slot written
                    end
                end
            end else begin
                byte_phase <= 1'b0;                          // Lone first byte is dropped
                if (href_fall &&
                    line_cnt != cctv_pkg::line_cnt_t'(cctv_pkg::frame_height)) begin
                    line_cnt <= line_cnt + cctv_pkg::line_cnt_t'(1);
                end
            end
        end
    end

    // Payload registers follow the phase without reset
    always_ff @(posedge pclk) begin
        if (href && !byte_phase) begin
            first_byte <= ov7670_data;                       // Hold until its partner arrives
        end
        if (href && byte_phase) begin
            pix.pix_rgb  <= packed_rgb;
            pix.pix_addr <= wr_addr;
        end
    end

endmodule

`default_nettype wire

//--- motion_differ.sv
`timescale 1ns/1ps
`default_nettype none

module motion_differ (
    input  wire                     pclk,
    input  wire                     rst_n,
    pixel_if.dst                    pix,
    input  wire cctv_pkg::pix_thresh_t pixel_threshold,
    output logic                    diff_valid,
    output logic                    diff_hit,
    output logic                    frame_done
);

    cctv_pkg::gray_t     prev_mem [cctv_pkg::frame_pixels]; // Gray of the previous frame
    cctv_pkg::gray_sum_t gray_sum;
    cctv_pkg::gray_t     cur_gray;   // Gray of the incoming pixel
    cctv_pkg::gray_t     prev_gray;  // Same pixel one frame earlier
    cctv_pkg::gray_t     abs_diff;
    logic                primed;     // Store holds a full previous frame

    // ********************
    // Gray conversion
    assign gray_sum = cctv_pkg::gray_sum_t'(pix.pix_rgb[11:8]) * cctv_pkg::gray_w_red
                    + cctv_pkg::gray_sum_t'(pix.pix_rgb[7:4])  * cctv_pkg::gray_w_green
                    + cctv_pkg::gray_sum_t'(pix.pix_rgb[3:0])  * cctv_pkg::gray_w_blue;
    assign cur_gray = gray_sum[7:4];                          // Divide by 16 and truncate

    // Read sees the old entry before this cycle's write lands
    assign prev_gray = prev_mem[pix.pix_addr];
    assign abs_diff  = (cur_gray > prev_gray) ? cur_gray - prev_gray
                                              : prev_gray - cur_gray;

    // ********************
    // Frame store
    always_ff @(posedge pclk) begin
        if (pix.pix_valid) begin
            prev_mem[pix.pix_addr] <= cur_gray;               // Replace with current frame
        end
    end

    // ********************
    // Change decision
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            diff_valid <= 1'b0;
            diff_hit   <= 1'b0;
            frame_done <= 1'b0;
            primed     <= 1'b0;
        end else begin
            diff_valid <= pix.pix_valid;                      // One cycle behind the pixel
            frame_done <= pix.frame_end;
            if (pix.frame_end) begin
                primed <= 1'b1;                               // First frame is now stored
            end
            if (pix.pix_valid) begin
                diff_hit <= primed && (abs_diff > pixel_threshold);
            end else begin
                diff_hit <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- motion_counter.sv
`timescale 1ns/1ps
`default_nettype none

module motion_counter (
    input  wire                     pclk,
    input  wire                     rst_n,
    input  wire                     diff_valid,
    input  wire                     diff_hit,
    input  wire                     frame_done,
    input  wire cctv_pkg::det_thresh_t detection_threshold,
    output logic                    motion_detected,
    output logic [15:0]             motion_detected_led,
    output cctv_pkg::diff_count_t   diff_pixel_cnt,
    output logic                    motion_update
);

    cctv_pkg::diff_count_t run_cnt;  // Hits so far in this frame
    logic                  hit;

    assign hit = diff_valid & diff_hit;

    // ********************
    // Running count
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            run_cnt <= '0;
        end else if (frame_done) begin
            run_cnt <= hit ? cctv_pkg::diff_count_t'(1) : '0; // New frame starts here
        end else if (hit) begin
            run_cnt <= run_cnt + cctv_pkg::diff_count_t'(1);
        end
    end

    // ********************
    // Frame result
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            motion_update   <= 1'b0;
            motion_detected <= 1'b0;
            diff_pixel_cnt  <= '0;
        end else begin
            motion_update <= frame_done;                       // Single pulse per frame
            if (frame_done) begin
                diff_pixel_cnt  <= run_cnt;
                motion_detected <= (run_cnt > detection_threshold); // Strictly above
            end
        end
    end

    // Decision is held so the LEDs stay lit between updates
    assign motion_detected_led = {16{motion_detected}};

endmodule

`default_nettype wire

//--- cctv_motion_top.sv
`timescale 1ns/1ps
`default_nettype none

module cctv_motion_top (
    input  wire                     pclk,
    input  wire                     rst_n,
    input  wire                     href,
    input  wire                     vref,
    input  wire cctv_pkg::cam_byte_t   ov7670_data,
    input  wire cctv_pkg::pix_thresh_t pixel_threshold,
    input  wire cctv_pkg::det_thresh_t detection_threshold,
    output logic                    motion_detected,
    output logic [15:0]             motion_detected_led,
    output cctv_pkg::diff_count_t   diff_pixel_cnt,
    output logic                    motion_update
);

    // ********************
    // Stage links
    pixel_if u_pix ();           // Capture to differencing

    logic diff_valid;            // Pixel compared this cycle
    logic diff_hit;              // Pixel changed beyond threshold
    logic frame_done;            // Frame boundary after differencing

    // ********************
    // Camera input
    camera_capture u_capture (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .href        (href),
        .vref        (vref),
        .ov7670_data (ov7670_data),
        .pix         (u_pix.src)
    );

    // Gray compare against stored frame
    motion_differ u_differ (
        .pclk            (pclk),
        .rst_n           (rst_n),
        .pix             (u_pix.dst),
        .pixel_threshold (pixel_threshold),
        .diff_valid      (diff_valid),
        .diff_hit        (diff_hit),
        .frame_done      (frame_done)
    );

    // Count and decide once per frame
    motion_counter u_counter (
        .pclk                (pclk),
        .rst_n               (rst_n),
        .diff_valid          (diff_valid),
        .diff_hit            (diff_hit),
        .frame_done          (frame_done),
        .detection_threshold (detection_threshold),
        .motion_detected     (motion_detected),
        .motion_detected_led (motion_detected_led),
        .diff_pixel_cnt      (diff_pixel_cnt),
        .motion_update       (motion_update)
    );

endmodule

`default_nettype wire

//--- cctv_motion_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cctv_motion_assert (
    input wire        pclk,
    input wire        rst_n,
    input wire        frame_done,
    input wire        motion_update,
    input wire        motion_detected,
    input wire [15:0] motion_detected_led
);

    // ********************
    // Result strobe and outputs
    a_single_update: assert property (
        @(posedge pclk) disable iff (!rst_n)
        motion_update |=> !motion_update                    // One pulse per frame
    ) else $error("motion_update high in two consecutive cycles");

    a_led_copy: assert property (
        @(posedge pclk) disable iff (!rst_n)
        motion_detected_led == {16{motion_detected}}        // All LEDs follow the decision
    ) else $error("motion_detected_led differs from motion_detected");

    a_hold: assert property (
        @(posedge pclk) disable iff (!rst_n)
        !$stable(motion_detected) |-> $past(frame_done)     // Only the frame result may move it
    ) else $error("motion_detected changed outside a frame update");

endmodule

// Attach to every counter stage
bind motion_counter cctv_motion_assert u_assert (.*);

`default_nettype wire

//--- tb_cctv_motion.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cctv_motion;

    localparam int clk_half       = 20;  // 40 ns pclk
    localparam int reset_cycles   = 16;
    localparam int drive_dly      = 2;   // Inputs move 2 ns after the rising edge
    localparam int update_timeout = 20;  // Cycles allowed from vref rise to motion_update

    logic                  pclk = 1'b0;
    logic                  rst_n, href, vref;
    cctv_pkg::cam_byte_t   ov7670_data;
    cctv_pkg::pix_thresh_t pixel_threshold;
    cctv_pkg::det_thresh_t detection_threshold;
    logic                  motion_detected, motion_update;
    logic [15:0]           motion_detected_led;
    cctv_pkg::diff_count_t diff_pixel_cnt;
    int                    errors = 0;
    int                    tests = 0;
    integer                seed = 25315;  // Line gap generator
    logic                  last_motion = 1'b0; // Decision expected to hold until next update

    cctv_motion_top uut (.*);

    always #(clk_half) pclk = ~pclk;

    // ********************
    // Camera side
    task automatic step;
        @(posedge pclk);
        #(drive_dly);
    endtask

    // R5 from R4 with its top bit repeated, then G6[5:3]
    function automatic cctv_pkg::cam_byte_t first_byte_of(input cctv_pkg::rgb_t rgb);
        return {rgb[11:8], rgb[11], rgb[7:5]};
    endfunction

    // G6[2:0] then B5, low bits padded like the camera does
    function automatic cctv_pkg::cam_byte_t second_byte_of(input cctv_pkg::rgb_t rgb);
        return {rgb[4], rgb[7:6], rgb[3:0], rgb[3]};
    endfunction

    task automatic send_line(input cctv_pkg::rgb_t fill, patch, input int plen, line_no);
        int             x;
        int             gap;
        cctv_pkg::rgb_t rgb;
        for (x = 0; x < cctv_pkg::frame_width; x++) begin
            rgb = (line_no * cctv_pkg::frame_width + x < plen) ? patch : fill; // Patch leads
            step;
            href        = 1'b1;
            ov7670_data = first_byte_of(rgb);
            step;
            ov7670_data = second_byte_of(rgb);
        end
        gap = 1 + ($unsigned($random(seed)) % 4);     // Blanking of 1 to 4 cycles
        step;
        href        = 1'b0;
        ov7670_data = '0;
        repeat (gap - 1) step;
    endtask

    // ********************
    // Compare tasks
    task automatic check_count(input string name, input cctv_pkg::diff_count_t got, exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_motion(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_led(input string name, input logic [15:0] got, exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Sampled on the falling edge, away from the DUT's register updates
    task automatic wait_update(input int case_no, output logic timed_out);
        int cycles;
        cycles    = 0;
        timed_out = 1'b0;
        @(negedge pclk);
        while (!motion_update && !timed_out) begin
            cycles++;
            if (cycles > update_timeout) begin
                $display("Timeout: no motion_update pulse after vref in case %0d", case_no);
                timed_out = 1'b1;
            end else begin
                @(negedge pclk);
            end
        end
    endtask

    // ********************
    // Case sequence
    initial begin
        string                 text;
        int                    fd, n_fields, plen, err_before, y;
        cctv_pkg::pix_thresh_t pth;
        cctv_pkg::det_thresh_t dth;
        cctv_pkg::rgb_t        fill, patch;
        cctv_pkg::diff_count_t exp_cnt;
        logic                  exp_mot;
        logic                  timed_out;
        rst_n = 1'b0;
        href = 1'b0;
        vref = 1'b0;
        ov7670_data = '0;
        pixel_threshold = '0;
        detection_threshold = '0;
        timed_out = 1'b0;
        repeat (reset_cycles) @(posedge pclk);
        #(drive_dly) rst_n = 1'b1;
        step;
        check_count("diff_pixel_cnt", diff_pixel_cnt, '0);        // Reset values
        check_motion("motion_detected", motion_detected, 1'b0);
        check_motion("motion_update", motion_update, 1'b0);
        check_led("motion_detected_led", motion_detected_led, '0);
        tests++;
        $display("reset: %s", (errors == 0) ? "ok" : "mismatch");
        fd = $fopen("motion_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open motion_cases.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(text, fd) != 0) begin
                n_fields = $sscanf(text, "%h %h %h %h %h %h %h",
                                   pth, dth, fill, patch, plen, exp_cnt, exp_mot);
                if (n_fields == 7) begin                          // Comment lines parse nothing
                    err_before          = errors;
                    pixel_threshold     = pth;
                    detection_threshold = dth;
                    for (y = 0; y < cctv_pkg::frame_height; y++) send_line(fill, patch, plen, y);
                    check_motion("motion_detected", motion_detected, last_motion); // Held value
                    check_led("motion_detected_led", motion_detected_led, {16{last_motion}});
                    vref = 1'b1;                                  // Frame ends at vref rise
                    wait_update(tests, timed_out);
                    if (timed_out) begin
                        errors++;
                    end else begin
                        check_count("diff_pixel_cnt", diff_pixel_cnt, exp_cnt);
                        check_motion("motion_detected", motion_detected, exp_mot);
                        check_led("motion_detected_led", motion_detected_led, {16{exp_mot}});
                    end
                    last_motion = exp_mot;
                    step;
                    vref = 1'b0;
                    repeat (2) step;
                    $display("case %0d: count 0x%h motion %b %s", tests, diff_pixel_cnt,
                             motion_detected, (errors == err_before) ? "ok" : "mismatch");
                    tests++;
                end
            end
            $fclose(fd);
        end
        if (tests < 2) begin
            $display("No frame cases were found in motion_cases.txt");
            errors++;
        end
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- motion_cases.txt
# pixel_threshold detection_threshold fill_rgb patch_rgb patch_len exp_count exp_motion (hex)
# Each line is one frame compared with the frame before it
2 0A 000 FFF 1C 00 0
2 0A 000 FFF 1C 00 0
2 0A 000 000 00 1C 1
2 0A 000 000 00 00 0
2 0A 000 FFF 0A 0A 0
2 0A 000 000 00 0A 0
8 0A 000 0F0 30 00 0
7 0A 000 000 00 30 1
7 0A 0F0 0F0 00 C0 1
2 0A 888 888 00 00 0
2 FF 888 F00 C0 C0 0
3 0A 00F F00 05 00 0

//--- verilog.f
cctv_pkg.sv
pixel_if.sv
camera_capture.sv
motion_differ.sv
motion_counter.sv
cctv_motion_top.sv
cctv_motion_assert.sv
tb_cctv_motion.sv

//--- Makefile
TOP := tb_cctv_motion

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f verilog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
